// ==== list.f ====
+incdir+tests
src/riscvPkg.sv
src/control.sv
src/immGen.sv
src/aluExec.sv
src/resultQueue.sv
src/execSlice.sv
tests/tb_execSlice.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execSlice testbench with Verilator
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_execSlice -Mdir obj_dir \
    && ./obj_dir/Vtb_execSlice > sim.log 2>&1 \
    ; cat sim.log \
    ; grep -q "^Test OK$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/tbVectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NumVec = 32;

issueT  vecIssue  [NumVec];
resultT vecExpect [NumVec];
int     vecCount;

// flags are {regWrite, memRead, memWrite}; rd is instr[11:7], storeData only on stores
task automatic addVec(
    input logic [31:0] instr,
    input logic [31:0] pc,
    input logic [31:0] rs1Val,
    input logic [31:0] rs2Val,
    input logic [2:0]  flags,
    input logic [31:0] wbData,
    input logic [31:0] nextPc
);
    vecIssue[vecCount]  = '{instr, pc, rs1Val, rs2Val};
    vecExpect[vecCount] = '{instr[11:7], flags[2], flags[1], flags[0], wbData,
                            flags[0] ? rs2Val : 32'h0, nextPc};
    vecCount++;
endtask

// columns: instr, pc, rs1Val, rs2Val, flags, wbData, nextPc
task automatic loadVectors();
    vecCount = 0;
    // R-type, rs1 negative, shift amount 20
    addVec(32'h002081B3, 32'h1000, 32'h80000010, 32'h14, 3'b100, 32'h80000024, 32'h1004); // add
    addVec(32'h402081B3, 32'h1000, 32'h80000010, 32'h14, 3'b100, 32'h7FFFFFFC, 32'h1004); // sub
    addVec(32'h002091B3, 32'h1000, 32'h80000010, 32'h14, 3'b100, 32'h01000000, 32'h1004); // sll
    addVec(32'h0020A1B3, 32'h1000, 32'h80000010, 32'h14, 3'b100, 32'h00000001, 32'h1004); // slt
    addVec(32'h0020B1B3, 32'h1000, 32'h80000010, 32'h14, 3'b100, 32'h00000000, 32'h1004); // sltu
    addVec(32'h0020C1B3, 32'h1000, 32'h80000010, 32'h14, 3'b100, 32'h80000004, 32'h1004); // xor
    addVec(32'h0020D1B3, 32'h1000, 32'h80000010, 32'h14, 3'b100, 32'h00000800, 32'h1004); // srl
    addVec(32'h4020D1B3, 32'h1000, 32'h80000010, 32'h14, 3'b100, 32'hFFFFF800, 32'h1004); // sra
    addVec(32'h0020E1B3, 32'h1000, 32'h80000010, 32'h14, 3'b100, 32'h80000014, 32'h1004); // or
    addVec(32'h0020F1B3, 32'h1000, 32'h80000010, 32'h14, 3'b100, 32'h00000010, 32'h1004); // and
    // I-type
    addVec(32'hFF808193, 32'h1000, 32'h80000010, 32'h0, 3'b100, 32'h80000008, 32'h1004); // addi -8
    addVec(32'h4040D193, 32'h1000, 32'h80000010, 32'h0, 3'b100, 32'hF8000001, 32'h1004); // srai 4
    addVec(32'hFFF0B193, 32'h1000, 32'h80000010, 32'h0, 3'b100, 32'h00000001, 32'h1004); // sltiu -1
    // branches, offset +16 except the bne at -16
    addVec(32'h00208863, 32'h2000, 32'h55, 32'h55, 3'b000, 32'h00000000, 32'h2010); // beq taken
    addVec(32'h00208863, 32'h2000, 32'h55, 32'h54, 3'b000, 32'h00000001, 32'h2004);
    addVec(32'hFE2098E3, 32'h2000, 32'h55, 32'h54, 3'b000, 32'h00000001, 32'h1FF0); // bne taken
    addVec(32'h00209863, 32'h2000, 32'h07, 32'h07, 3'b000, 32'h00000000, 32'h2004);
    addVec(32'h0020C863, 32'h2000, 32'hFFFFFFFF, 32'h1, 3'b000, 32'hFFFFFFFE, 32'h2010); // blt
    addVec(32'h0020C863, 32'h2000, 32'h1, 32'hFFFFFFFF, 3'b000, 32'h00000002, 32'h2004);
    addVec(32'h0020D863, 32'h2000, 32'h1, 32'hFFFFFFFF, 3'b000, 32'h00000002, 32'h2010); // bge
    addVec(32'h0020D863, 32'h2000, 32'hFFFFFFFF, 32'h1, 3'b000, 32'hFFFFFFFE, 32'h2004);
    addVec(32'h0020E863, 32'h2000, 32'h1, 32'hFFFFFFFF, 3'b000, 32'h00000002, 32'h2010); // bltu
    addVec(32'h0020E863, 32'h2000, 32'hFFFFFFFF, 32'h1, 3'b000, 32'hFFFFFFFE, 32'h2004);
    addVec(32'h0020F863, 32'h2000, 32'hFFFFFFFF, 32'h1, 3'b000, 32'hFFFFFFFE, 32'h2010); // bgeu
    addVec(32'h0020F863, 32'h2000, 32'h1, 32'hFFFFFFFF, 3'b000, 32'h00000002, 32'h2004);
    // jumps and upper immediates
    addVec(32'h100000EF, 32'h3000, 32'h0, 32'h0, 3'b100, 32'h00003004, 32'h3100); // jal +256
    addVec(32'h005100E7, 32'h3000, 32'h4000, 32'h0, 3'b100, 32'h00003004, 32'h4004); // jalr 5
    addVec(32'hABCDE2B7, 32'h3000, 32'h0, 32'h0, 3'b100, 32'hABCDE000, 32'h3004); // lui
    addVec(32'h12345297, 32'h3000, 32'h0, 32'h0, 3'b100, 32'h12348000, 32'h3004); // auipc
    // memory and an unknown opcode
    addVec(32'hFFC0A303, 32'h4000, 32'h1000, 32'h0, 3'b110, 32'h00000FFC, 32'h4004); // lw -4
    addVec(32'h0020A623, 32'h4000, 32'h1000, 32'hDEADBEEF, 3'b001, 32'h100C, 32'h4004); // sw 12
    addVec(32'h0020807B, 32'h4000, 32'h10, 32'h20, 3'b000, 32'h00000030, 32'h4004);
endtask

`endif

// ==== tests/tb_execSlice.sv ====
`timescale 1ns/100ps

module tb_execSlice;

    import riscvPkg::*;

    localparam int QueueDepth  = 4;
    localparam int CreditWidth = 3;

    logic   clk;
    logic   rst;
    logic   issueValid;
    issueT  issue;
    logic   outCredit;
    logic   issueCredit;
    logic   outValid;
    resultT result;

    int errors          = 0;
    int rxCount         = 0;
    int creditPulses    = 0;
    int cycle           = 0;
    int firstIssueCycle = 0;
    int seed            = 59240;

    `include "tbVectors.svh"

    execSlice #(
        .QueueDepth  (QueueDepth),
        .CreditWidth (CreditWidth)
    ) execSlice_inst (
        .clk         (clk),
        .rst         (rst),
        .issueValid  (issueValid),
        .issue       (issue),
        .outCredit   (outCredit),
        .issueCredit (issueCredit),
        .outValid    (outValid),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // upstream spends one credit per issue
    initial begin : issueDriver
        int credits;
        int idx;
        credits    = QueueDepth;
        idx        = 0;
        issueValid = 1'b0;
        issue      = '0;
        loadVectors();
        wait (!rst);
        repeat (4) @(negedge clk); // let the first downstream credit land
        while (idx < NumVec) begin
            @(negedge clk);
            if (issueCredit) credits++;
            if (credits > 0) begin
                issueValid = 1'b1;
                issue      = vecIssue[idx];
                if (idx == 0) firstIssueCycle = cycle;
                credits--;
                idx++;
            end else begin
                issueValid = 1'b0;
            end
        end
        @(negedge clk);
        issueValid = 1'b0;
    end

    // downstream grants one credit, stalls, then grants at random
    initial begin : creditGranter
        int granted;
        int delivered;
        granted   = 0;
        delivered = 0;
        outCredit = 1'b0;
        wait (!rst);
        @(negedge clk);
        outCredit = 1'b1;
        granted   = 1;
        @(negedge clk);
        outCredit = 1'b0;
        do @(negedge clk); while (!outValid);
        delivered = 1;
        repeat (30) @(negedge clk); // upstream runs out of credits here
        forever begin
            @(negedge clk);
            if (outValid) delivered++;
            outCredit = (($random(seed) & 1) == 1) && (granted - delivered < QueueDepth);
            if (outCredit) granted++;
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (issueCredit) creditPulses++;
            if (outValid) begin
                assert (rxCount < NumVec) else begin
                    errors++;
                    $display("a result arrived after the whole table was already received");
                end
                if (rxCount < NumVec) begin
                    assert (result === vecExpect[rxCount]) else begin
                        errors++;
                        $display("[ERROR] %0t result %0d: got %h expected %h",
                                 $time, rxCount, result, vecExpect[rxCount]);
                    end
                    if (rxCount == 0) begin
                        assert (cycle - firstIssueCycle == 2) else begin
                            errors++;
                            $display("[ERROR] %0t first result latency %0d, expected 2",
                                     $time, cycle - firstIssueCycle);
                        end
                    end
                    rxCount++;
                end
            end
        end
    end

    initial begin : finishRun
        wait (rxCount == NumVec);
        repeat (10) @(negedge clk); // catch stray results and credits
        assert (creditPulses == rxCount) else begin
            errors++;
            $display("[ERROR] %0t issueCredit pulses %0d for %0d results",
                     $time, creditPulses, rxCount);
        end
        $display("results %0d of %0d, errors %0d", rxCount, NumVec, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (8 + NumVec * 40) @(posedge clk);
        $display("timeout with results missing, only %0d of %0d arrived, errors %0d",
                 rxCount, NumVec, errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== src/execSlice.sv ====
`timescale 1ns/100ps

module execSlice #(
    parameter int QueueDepth  = 4,
    parameter int CreditWidth = 3 // must hold QueueDepth
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             issueValid,
    input  riscvPkg::issueT  issue,
    input  logic             outCredit,
    output logic             issueCredit,
    output logic             outValid,
    output riscvPkg::resultT result
);

    import riscvPkg::*;

    ctrlT            ctrl;
    logic [XLEN-1:0] imm;
    logic            execValid;
    resultT          execResult;

    // decode and immediate run side by side on the same word
    control control_inst (
        .instr (issue.instr),
        .ctrl  (ctrl)
    );

    immGen immGen_inst (
        .instr  (issue.instr),
        .immSrc (ctrl.immSrc),
        .imm    (imm)
    );

    aluExec aluExec_inst (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid),
        .issue      (issue),
        .ctrl       (ctrl),
        .imm        (imm),
        .execValid  (execValid),
        .execResult (execResult)
    );

    resultQueue #(
        .QueueDepth  (QueueDepth),
        .CreditWidth (CreditWidth)
    ) resultQueue_inst (
        .clk         (clk),
        .rst         (rst),
        .execValid   (execValid),
        .execResult  (execResult),
        .outCredit   (outCredit),
        .outValid    (outValid),
        .result      (result),
        .issueCredit (issueCredit)
    );

endmodule

// ==== src/resultQueue.sv ====
`timescale 1ns/100ps

module resultQueue #(
    parameter int QueueDepth  = 4,
    parameter int CreditWidth = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             execValid,
    input  riscvPkg::resultT execResult,
    input  logic             outCredit,
    output logic             outValid,
    output riscvPkg::resultT result,
    output logic             issueCredit
);

    import riscvPkg::*;

    localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;

    resultT                 mem [QueueDepth];
    logic [PtrWidth-1:0]    wrPtr;
    logic [PtrWidth-1:0]    rdPtr;
    logic [CreditWidth-1:0] count; // entries held
    logic [CreditWidth-1:0] creditCnt; // downstream credits held
    logic                   pop;
    resultT                 popData;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // an empty queue passes the incoming result straight through
    assign pop     = (count != '0 || execValid) && creditCnt != '0;
    assign popData = (count == '0) ? execResult : mem[rdPtr];

    always_ff @(posedge clk) begin
        if (execValid) mem[wrPtr] <= execResult; // harmless on bypass
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            creditCnt <= '0;
        end else begin
            if (execValid) wrPtr <= nextPtr(wrPtr);
            if (pop)       rdPtr <= nextPtr(rdPtr);
            count     <= count + CreditWidth'(execValid) - CreditWidth'(pop);
            creditCnt <= creditCnt + CreditWidth'(outCredit) - CreditWidth'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid    <= 1'b0;
            issueCredit <= 1'b0;
        end else begin
            outValid    <= pop;
            issueCredit <= pop; // one credit back per result sent
        end
    end

    always_ff @(posedge clk) begin
        if (pop) result <= popData;
    end

    // upstream credits keep the queue from overflowing
    assert property (@(posedge clk) disable iff (rst)
        execValid |-> count != CreditWidth'(QueueDepth));

    // downstream grants no more than the queue can deliver
    assert property (@(posedge clk) disable iff (rst)
        creditCnt <= CreditWidth'(QueueDepth));

endmodule

// ==== src/aluExec.sv ====
`timescale 1ns/100ps

module aluExec (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issueValid,
    input  riscvPkg::issueT           issue,
    input  riscvPkg::ctrlT            ctrl,
    input  logic [riscvPkg::XLEN-1:0] imm,
    output logic                      execValid,
    output riscvPkg::resultT          execResult
);

    import riscvPkg::*;

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcTarget;
    logic [XLEN-1:0] nextPc;
    logic [XLEN-1:0] wbData;
    logic            isAuipc;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic            taken;
    resultT          nextResult;

    assign isAuipc = issue.instr[6:0] == AUIPC;
    assign opA     = isAuipc ? issue.pc : issue.rs1Val;
    assign opB     = ctrl.aluSrc ? imm : issue.rs2Val;

    // compare flags, shared by slt and the branches
    assign eq  = opA == opB;
    assign lt  = $signed(opA) < $signed(opB);
    assign ltu = opA < opB;

    always_comb begin
        case (ctrl.aluOp)
            SUB:     aluResult = opA - opB;
            AND:     aluResult = opA & opB;
            OR:      aluResult = opA | opB;
            XOR:     aluResult = opA ^ opB;
            SLL:     aluResult = opA << opB[4:0];
            SRL:     aluResult = opA >> opB[4:0];
            SRA:     aluResult = $signed(opA) >>> opB[4:0];
            SLT:     aluResult = {{(XLEN-1){1'b0}}, lt};
            SLTU:    aluResult = {{(XLEN-1){1'b0}}, ltu};
            default: aluResult = opA + opB;
        endcase
    end

    always_comb begin
        case (ctrl.branch)
            EQ:      taken = eq;
            NE:      taken = !eq;
            LT:      taken = lt;
            GE:      taken = !lt;
            LTU:     taken = ltu;
            GEU:     taken = !ltu;
            ALWAYS:  taken = 1'b1; // jal
            default: taken = 1'b0; // jalr goes through its own path
        endcase
    end

    assign pcPlus4  = issue.pc + XLEN'(4);
    assign pcTarget = issue.pc + imm;

    always_comb begin
        if (ctrl.branch == REG) nextPc = {aluResult[XLEN-1:1], 1'b0}; // jalr
        else if (taken)         nextPc = pcTarget;
        else                    nextPc = pcPlus4;
    end

    always_comb begin
        case (ctrl.resultSrc)
            PC4:     wbData = pcPlus4;
            IMM:     wbData = imm;
            default: wbData = aluResult; // address for loads and stores
        endcase
    end

    always_comb begin
        nextResult.rd        = issue.instr[11:7];
        nextResult.regWrite  = ctrl.regWrite;
        nextResult.memRead   = ctrl.resultSrc == MEM;
        nextResult.memWrite  = ctrl.memWrite;
        nextResult.wbData    = wbData;
        nextResult.storeData = ctrl.memWrite ? issue.rs2Val : '0;
        nextResult.nextPc    = nextPc;
    end

    always_ff @(posedge clk) begin
        if (rst) execValid <= 1'b0;
        else     execValid <= issueValid;
    end

    always_ff @(posedge clk) begin
        if (issueValid) execResult <= nextResult; // payload, no reset
    end

    // decoder never asks for a load and a store at once
    assert property (@(posedge clk) disable iff (rst)
        execValid |-> !(execResult.memRead && execResult.memWrite));

endmodule

// ==== src/immGen.sv ====
`timescale 1ns/100ps

module immGen (
    input  logic [31:0]              instr,
    input  riscvPkg::immSrcE         immSrc,
    output logic [riscvPkg::XLEN-1:0] imm
);

    import riscvPkg::*;

    logic sign;

    assign sign = instr[31]; // every format takes its sign from bit 31

    always_comb begin
        case (immSrc)
            IMM_I: imm = {{20{sign}}, instr[31:20]};
            IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            IMM_B: imm = {{19{sign}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0}; // halfword offset
            IMM_J: imm = {{11{sign}}, instr[31], instr[19:12], instr[20],
                          instr[30:21], 1'b0};
            IMM_U: imm = {instr[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

endmodule

// ==== src/control.sv ====
`timescale 1ns/100ps

module control (
    input  logic [31:0]     instr,
    output riscvPkg::ctrlT ctrl
);

    import riscvPkg::*;

    opcodeE     opcode;
    logic [2:0] funct3;
    logic       funct7b5; // instr[30], sub/sra select

    assign opcode   = opcodeE'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // alu operation for OP and OP_IMM
    function automatic aluOpE decodeAluOp(
        input logic [2:0] f3,
        input logic       f7,
        input logic       isImm
    );
        aluOpE op;
        op = ADD;
        case (f3)
            3'd0: op = (f7 && !isImm) ? SUB : ADD; // addi never subtracts
            3'd1: op = SLL;
            3'd2: op = SLT;
            3'd3: op = SLTU;
            3'd4: op = XOR;
            3'd5: op = f7 ? SRA : SRL; // srai keeps bit 30
            3'd6: op = OR;
            3'd7: op = AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl = '0; // everything inactive unless decoded
        case (opcode)
            OP: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = decodeAluOp(funct3, funct7b5, 1'b0);
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = decodeAluOp(funct3, funct7b5, 1'b1);
            end
            LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = MEM;
            end
            STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = IMM_S;
            end
            BRANCH: begin
                ctrl.aluOp  = SUB;
                ctrl.immSrc = IMM_B;
                case (funct3)
                    3'b000:  ctrl.branch = EQ;
                    3'b001:  ctrl.branch = NE;
                    3'b100:  ctrl.branch = LT;
                    3'b101:  ctrl.branch = GE;
                    3'b110:  ctrl.branch = LTU;
                    3'b111:  ctrl.branch = GEU;
                    default: ctrl.branch = NONE; // reserved funct3
                endcase
            end
            JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_J;
                ctrl.resultSrc = PC4;
                ctrl.branch    = ALWAYS;
            end
            JALR: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1; // target = rs1 + imm
                ctrl.resultSrc = PC4;
                ctrl.branch    = REG;
            end
            LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_U;
                ctrl.resultSrc = IMM;
            end
            AUIPC: begin
                ctrl.regWrite = 1'b1;
                ctrl.immSrc   = IMM_U;
                ctrl.aluSrc   = 1'b1; // pc + imm
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== src/riscvPkg.sv ====
package riscvPkg;

    localparam int XLEN = 32; // datapath width

    // base opcodes handled by the slice
    typedef enum logic [6:0] {
        OP     = 7'b0110011, // register-register alu
        OP_IMM = 7'b0010011, // register-immediate alu
        LOAD   = 7'b0000011,
        JALR   = 7'b1100111,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcodeE;

    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b0001,
        AND  = 4'b0010,
        OR   = 4'b0011,
        XOR  = 4'b0100,
        SLL  = 4'b0101,
        SRA  = 4'b0110,
        SRL  = 4'b0111,
        SLT  = 4'b1000,
        SLTU = 4'b1001
    } aluOpE;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } immSrcE;

    typedef enum logic [1:0] {
        ALU = 2'b00, // alu result, also the load/store address
        MEM = 2'b01,
        PC4 = 2'b10, // link value for jal/jalr
        IMM = 2'b11
    } resultSrcE;

    // nine conditions, so this needs four bits
    typedef enum logic [3:0] {
        NONE, EQ, NE, LT, GE, LTU, GEU, ALWAYS, REG
    } branchE;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      aluSrc; // 1 selects imm as operand b
        aluOpE     aluOp;
        immSrcE    immSrc;
        resultSrcE resultSrc;
        branchE    branch;
    } ctrlT;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1Val;
        logic [XLEN-1:0] rs2Val;
    } issueT;

    typedef struct packed {
        logic [4:0]      rd;
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
        logic [XLEN-1:0] wbData; // alu result or memory address
        logic [XLEN-1:0] storeData;
        logic [XLEN-1:0] nextPc;
    } resultT;

endpackage
